// File: hw/aqp_defines.svh
`ifndef AQP_DEFINES_SVH
`define AQP_DEFINES_SVH

////////////////////////////////////////
// Bus synchronizer
////////////////////////////////////////
`define AQP_SYNC_STAGES     3

////////////////////////////////////////
// IO register addresses
////////////////////////////////////////
`define AQP_IO_BANK0        8'hF0
`define AQP_IO_BANK1        8'hF1
`define AQP_IO_BANK2        8'hF2
`define AQP_IO_BANK3        8'hF3
`define AQP_IO_SYSCTRL      8'hFB
`define AQP_IO_CASSETTE     8'hFC
`define AQP_IO_PRINTER      8'hFE

////////////////////////////////////////
// Physical pages and overlay windows
////////////////////////////////////////
`define AQP_PAGE_ROM_LAST   6'd3
`define AQP_PAGE_VRAM       6'd20
`define AQP_PAGE_CHRAM      6'd21
`define AQP_CART_PAGE_HI    4'b0100     // Pages 16-19
`define AQP_WIN_TRAM        3'd6        // $3000-$37FF
`define AQP_WIN_SYSRAM      3'd7        // $3800-$3FFF

// Bank register values out of reset
`define AQP_BANK0_RESET     8'hC0       // RO + overlay, page 0
`define AQP_BANK1_RESET     8'h21       // Page 33
`define AQP_BANK2_RESET     8'h22       // Page 34
`define AQP_BANK3_RESET     8'h13       // Page 19, cartridge

`endif

// File: hw/aqp_pkg.sv
package aqp_pkg;

    // Host bus
    typedef logic [15:0] bus_addr_t;
    typedef logic [7:0]  bus_data_t;

    // Memory banking
    typedef logic [5:0]  page_t;        // 64 pages of 16 KB

    // Bank register layout
    //   bit 7     read-only
    //   bit 6     overlay enable
    //   bits 5..0 physical page
    typedef logic [7:0]  bank_t;

    // Upper address lines of the external memory
    typedef logic [4:0]  bank_addr_t;

endpackage

// File: hw/host_bus_if.sv
`timescale 1ns/100ps

interface host_bus_if
    import aqp_pkg::*;
();

    bus_addr_t addr;
    logic      mreq_n;
    logic      iorq_n;
    logic      rd_n;
    logic      wr_n;
    bus_data_t wrdata;      // Captured while wr_n low
    logic      bus_write;   // One clock per host write

    modport producer (
        output addr, mreq_n, iorq_n, rd_n, wr_n,
        output wrdata, bus_write
    );

    modport consumer (
        input addr, mreq_n, iorq_n, rd_n, wr_n,
        input wrdata, bus_write
    );

endinterface

// File: hw/bus_sync.sv
`timescale 1ns/100ps
`include "aqp_defines.svh"

module bus_sync
    import aqp_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  bus_addr_t    a,
    input  bus_data_t    d_in,
    input  logic         mreq_n,
    input  logic         iorq_n,
    input  logic         rd_n,
    input  logic         wr_n,
    input  logic         cassette_in,
    input  logic         printer_in,
    output logic         cassette_s,
    output logic         printer_s,
    host_bus_if.producer host
);

    localparam int SYNC = `AQP_SYNC_STAGES;

    logic [SYNC-1:0]      wr_n_sync;
    logic [SYNC-1:0][1:0] port_sync;    // {printer, cassette} per stage
    bus_data_t            wrdata_r;

    // Decode runs on the raw levels
    assign host.addr   = a;
    assign host.mreq_n = mreq_n;
    assign host.iorq_n = iorq_n;
    assign host.rd_n   = rd_n;
    assign host.wr_n   = wr_n;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_n_sync <= '1;    // Bus idle
            port_sync <= '0;
        end else begin
            wr_n_sync <= {wr_n_sync[SYNC-2:0], wr_n};
            port_sync <= {port_sync[SYNC-2:0], {printer_in, cassette_in}};
        end
    end

    // Keeps the last byte seen during the strobe
    always_ff @(posedge clk) begin
        if (!wr_n)
            wrdata_r <= d_in;
    end

    assign host.wrdata    = wrdata_r;
    assign host.bus_write = wr_n_sync[SYNC-1] & ~wr_n_sync[SYNC-2];   // Falling edge

    assign cassette_s = port_sync[SYNC-1][0];
    assign printer_s  = port_sync[SYNC-1][1];

endmodule

// File: hw/io_regs.sv
`timescale 1ns/100ps
`include "aqp_defines.svh"

module io_regs
    import aqp_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         cassette_s,
    input  logic         printer_s,
    host_bus_if.consumer host,
    output bank_t        cur_bank,
    output logic         io_hit,
    output bus_data_t    io_rddata,
    output logic         cassette_out,
    output logic         printer_out
);

    bank_t      bank_r [4];
    logic [1:0] sysctrl_r;      // {dis_psgs, dis_regs}
    logic [3:0] sel_bank;
    logic       bank_en;
    logic       sel_sysctrl;
    logic       sel_cassette;
    logic       sel_printer;

    ////////////////////////////////////////
    // IO decode
    ////////////////////////////////////////
    assign bank_en = !host.iorq_n && !sysctrl_r[0];

    assign sel_bank[0] = bank_en && host.addr[7:0] == `AQP_IO_BANK0;
    assign sel_bank[1] = bank_en && host.addr[7:0] == `AQP_IO_BANK1;
    assign sel_bank[2] = bank_en && host.addr[7:0] == `AQP_IO_BANK2;
    assign sel_bank[3] = bank_en && host.addr[7:0] == `AQP_IO_BANK3;

    // Always visible, even with the bank registers hidden
    assign sel_sysctrl  = !host.iorq_n && host.addr[7:0] == `AQP_IO_SYSCTRL;
    assign sel_cassette = !host.iorq_n && host.addr[7:0] == `AQP_IO_CASSETTE;
    assign sel_printer  = !host.iorq_n && host.addr[7:0] == `AQP_IO_PRINTER;

    assign io_hit = |sel_bank || sel_sysctrl || sel_cassette || sel_printer;

    ////////////////////////////////////////
    // Registers
    ////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bank_r[0]    <= `AQP_BANK0_RESET;
            bank_r[1]    <= `AQP_BANK1_RESET;
            bank_r[2]    <= `AQP_BANK2_RESET;
            bank_r[3]    <= `AQP_BANK3_RESET;
            sysctrl_r    <= 2'b00;
            cassette_out <= 1'b0;
            printer_out  <= 1'b0;
        end else if (host.bus_write) begin
            for (int i = 0; i < 4; i++) begin
                if (sel_bank[i])
                    bank_r[i] <= host.wrdata;
            end
            if (sel_sysctrl)
                sysctrl_r <= host.wrdata[1:0];
            if (sel_cassette)
                cassette_out <= host.wrdata[0];
            if (sel_printer)
                printer_out <= host.wrdata[0];
        end
    end

    ////////////////////////////////////////
    // Readback
    ////////////////////////////////////////
    always_comb begin
        io_rddata = 8'h00;
        for (int i = 0; i < 4; i++) begin
            if (sel_bank[i])
                io_rddata = bank_r[i];
        end
        if (sel_sysctrl)
            io_rddata = {6'b0, sysctrl_r};
        if (sel_cassette)
            io_rddata = {7'b0, ~cassette_s};    // Input is inverted on the port
        if (sel_printer)
            io_rddata = {7'b0, printer_s};
    end

    // One bank register per 16 KB quarter
    assign cur_bank = bank_r[host.addr[15:14]];

endmodule

// File: hw/mem_map.sv
`timescale 1ns/100ps
`include "aqp_defines.svh"

module mem_map
    import aqp_pkg::*;
(
    host_bus_if.consumer host,
    input  bank_t        cur_bank,
    input  logic         io_hit,
    input  bus_data_t    io_rddata,
    output bank_addr_t   ba,
    output logic         ram_ce_n,
    output logic         cart_ce_n,
    output logic         ram_we_n,
    output bus_data_t    d_out,
    output logic         d_oe
);

    page_t page;
    logic  overlay;
    logic  read_only;
    logic  mem;
    logic  sel_sysram;
    logic  sel_tram;
    logic  sel_vram;
    logic  sel_chram;
    logic  sel_rom;
    logic  sel_internal;
    logic  allow_mem;
    logic  sel_cart;
    logic  sel_ram;

    assign page      = cur_bank[5:0];
    assign overlay   = cur_bank[6];
    assign read_only = cur_bank[7];
    assign mem       = !host.mreq_n;

    ////////////////////////////////////////
    // Window decode
    ////////////////////////////////////////
    assign sel_sysram = mem && overlay && host.addr[13:11] == `AQP_WIN_SYSRAM;
    assign sel_tram   = mem && overlay && host.addr[13:11] == `AQP_WIN_TRAM;
    assign sel_vram   = mem && page == `AQP_PAGE_VRAM;
    assign sel_chram  = mem && page == `AQP_PAGE_CHRAM;
    assign sel_rom    = mem && page <= `AQP_PAGE_ROM_LAST && !sel_sysram;

    // Windows that are served on chip and never reach the external bus
    assign sel_internal = sel_tram || sel_vram || sel_chram || sel_rom;

    // Writes to a read-only bank select nothing
    assign allow_mem = mem && !sel_internal && !io_hit && !sel_sysram &&
                       (host.wr_n || !read_only);

    assign sel_cart = allow_mem && page[5:2] == `AQP_CART_PAGE_HI;
    assign sel_ram  = (allow_mem && page[5]) || sel_sysram;     // Pages 32-63

    ////////////////////////////////////////
    // External memory strobes
    ////////////////////////////////////////
    assign ram_ce_n  = !sel_ram;
    assign cart_ce_n = !sel_cart;
    assign ram_we_n  = !(!host.wr_n && (sel_sysram || (sel_ram && !read_only)));

    assign ba = sel_sysram ? '0 : page[4:0];    // System RAM lives in page 32

    // Host data bus drive
    assign d_oe  = !host.rd_n && (io_hit || sel_internal);
    assign d_out = io_hit ? io_rddata : 8'h00;

endmodule

// File: hw/aqp_bus_top.sv
`timescale 1ns/100ps

module aqp_bus_top
    import aqp_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    // Z80 host bus
    input  bus_addr_t  a,
    input  bus_data_t  d_in,
    input  logic       mreq_n,
    input  logic       iorq_n,
    input  logic       rd_n,
    input  logic       wr_n,
    output bus_data_t  d_out,
    output logic       d_oe,

    // External memory
    output bank_addr_t ba,
    output logic       ram_ce_n,
    output logic       cart_ce_n,
    output logic       ram_we_n,

    // Ports
    input  logic       cassette_in,
    input  logic       printer_in,
    output logic       cassette_out,
    output logic       printer_out
);

    bank_t     cur_bank;
    logic      io_hit;
    bus_data_t io_rddata;
    logic      cassette_s;
    logic      printer_s;

    host_bus_if host_bus ();

    ////////////////////////////////////////
    // Input side
    ////////////////////////////////////////
    bus_sync u_bus_sync (
        .clk         (clk),
        .reset       (reset),
        .a           (a),
        .d_in        (d_in),
        .mreq_n      (mreq_n),
        .iorq_n      (iorq_n),
        .rd_n        (rd_n),
        .wr_n        (wr_n),
        .cassette_in (cassette_in),
        .printer_in  (printer_in),
        .cassette_s  (cassette_s),
        .printer_s   (printer_s),
        .host        (host_bus)
    );

    io_regs u_io_regs (
        .clk          (clk),
        .reset        (reset),
        .cassette_s   (cassette_s),
        .printer_s    (printer_s),
        .host         (host_bus),
        .cur_bank     (cur_bank),
        .io_hit       (io_hit),
        .io_rddata    (io_rddata),
        .cassette_out (cassette_out),
        .printer_out  (printer_out)
    );

    // Output side is purely combinational
    mem_map u_mem_map (
        .host      (host_bus),
        .cur_bank  (cur_bank),
        .io_hit    (io_hit),
        .io_rddata (io_rddata),
        .ba        (ba),
        .ram_ce_n  (ram_ce_n),
        .cart_ce_n (cart_ce_n),
        .ram_we_n  (ram_we_n),
        .d_out     (d_out),
        .d_oe      (d_oe)
    );

endmodule

// File: tb/tb_aqp_bus.sv
`timescale 1ns/100ps

module tb_aqp_bus
    import aqp_pkg::*;
();

    localparam int MAX_OPS      = 200;
    localparam int RESET_CYCLES = 8;

    logic       clk;
    logic       reset;
    bus_addr_t  a;
    bus_data_t  d_in;
    logic       mreq_n;
    logic       iorq_n;
    logic       rd_n;
    logic       wr_n;
    logic       cassette_in;
    logic       printer_in;
    bus_data_t  d_out;
    logic       d_oe;
    bank_addr_t ba;
    logic       ram_ce_n;
    logic       cart_ce_n;
    logic       ram_we_n;
    logic       cassette_out;
    logic       printer_out;

    int          fd;
    int          code;
    int          ops;
    int          checks;
    int          errors;
    int unsigned idle;
    bit          done;
    bit          timed_out;
    logic [7:0]  op;
    logic [15:0] f_addr;
    logic [7:0]  f1, f2, f3, f4, f5, f6;
    logic [8*128-1:0] line;
    string       tag;

    aqp_bus_top dut (.*);

    always #10 clk = ~clk;  // 20 ns period

    ////////////////////////////////////////
    // Bus operations
    ////////////////////////////////////////
    task automatic check(input string name, input logic [15:0] exp, input logic [15:0] act);
        checks++;
        assert (act === exp) else begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic io_write(input bus_addr_t addr, input bus_data_t data);
        @(posedge clk);
        a      <= addr;
        d_in   <= data;
        iorq_n <= 1'b0;
        wr_n   <= 1'b0;
        repeat (6) @(posedge clk);  // Host write hold time
        iorq_n <= 1'b1;
        wr_n   <= 1'b1;
        repeat (2) @(posedge clk);
    endtask

    task automatic io_read(input bus_addr_t addr, input bus_data_t exp_d, input logic exp_oe);
        @(posedge clk);
        a      <= addr;
        iorq_n <= 1'b0;
        rd_n   <= 1'b0;
        @(negedge clk);
        check({tag, " d_out"}, exp_d, d_out);
        check({tag, " d_oe"}, exp_oe, d_oe);
        @(posedge clk);
        iorq_n <= 1'b1;
        rd_n   <= 1'b1;
    endtask

    task automatic mem_access(input bus_addr_t addr, input logic write, input logic exp_ram_ce_n,
                              input logic exp_cart_ce_n, input logic exp_we_n,
                              input bank_addr_t exp_ba, input logic exp_oe);
        @(posedge clk);
        a      <= addr;
        mreq_n <= 1'b0;
        rd_n   <= write;
        wr_n   <= !write;
        @(negedge clk);
        check({tag, " ram_ce_n"}, exp_ram_ce_n, ram_ce_n);
        check({tag, " cart_ce_n"}, exp_cart_ce_n, cart_ce_n);
        check({tag, " ram_we_n"}, exp_we_n, ram_we_n);
        check({tag, " ba"}, exp_ba, ba);
        check({tag, " d_oe"}, exp_oe, d_oe);
        if (exp_oe)
            check({tag, " d_out"}, 8'h00, d_out);   // Internal windows read as zero
        @(posedge clk);
        mreq_n <= 1'b1;
        rd_n   <= 1'b1;
        wr_n   <= 1'b1;
        repeat (2) @(posedge clk);  // Let the strobe synchronizer settle
    endtask

    task automatic set_ports(input logic cas, input logic prn);
        @(posedge clk);
        cassette_in <= cas;
        printer_in  <= prn;
        repeat (4) @(posedge clk);
    endtask

    task automatic check_ports(input logic exp_cas, input logic exp_prn);
        @(negedge clk);
        check({tag, " cassette_out"}, exp_cas, cassette_out);
        check({tag, " printer_out"}, exp_prn, printer_out);
    endtask

    ////////////////////////////////////////
    // Golden file replay
    ////////////////////////////////////////
    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        a           = '0;
        d_in        = '0;
        mreq_n      = 1'b1;
        iorq_n      = 1'b1;
        rd_n        = 1'b1;
        wr_n        = 1'b1;
        cassette_in = 1'b0;
        printer_in  = 1'b0;
        ops         = 0;
        checks      = 0;
        errors      = 0;
        done        = 1'b0;
        timed_out   = 1'b0;
        idle        = $urandom(79);

        for (int i = 0; i < RESET_CYCLES; i++)
            @(posedge clk);
        reset <= 1'b0;

        fd = $fopen("tb/aqp_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file tb/aqp_golden.txt");
            errors++;
        end

        while (fd != 0 && !done) begin
            code = $fscanf(fd, " %c", op);
            if (code != 1) begin
                done = 1'b1;    // End of file
            end else if (op == "#") begin
                code = $fgets(line, fd);
            end else if (ops == MAX_OPS) begin
                $display("Timeout: %0d operations replayed without reaching end of file", ops);
                timed_out = 1'b1;
                done      = 1'b1;
            end else begin
                tag = $sformatf("op %0d %c", ops, op);
                case (op)
                    "W": begin
                        code = $fscanf(fd, "%h %h", f_addr, f1);
                        io_write(f_addr, f1);
                    end
                    "R": begin
                        code = $fscanf(fd, "%h %h %h", f_addr, f1, f2);
                        io_read(f_addr, f1, f2[0]);
                    end
                    "M": begin
                        code = $fscanf(fd, "%h %h %h %h %h %h %h",
                                       f_addr, f1, f2, f3, f4, f5, f6);
                        mem_access(f_addr, f1[0], f2[0], f3[0], f4[0], f5[4:0], f6[0]);
                    end
                    "P": begin
                        code = $fscanf(fd, "%h %h", f1, f2);
                        set_ports(f1[0], f2[0]);
                    end
                    "C": begin
                        code = $fscanf(fd, "%h %h", f1, f2);
                        check_ports(f1[0], f2[0]);
                    end
                    default: begin
                        $display("Unknown operation letter %c in the golden file", op);
                        errors++;
                        code = $fgets(line, fd);
                    end
                endcase
                ops++;
                idle = $urandom % 4;    // Random bus idle time
                repeat (idle) @(posedge clk);
            end
        end

        if (fd != 0)
            $fclose(fd);

        $display("Operations: %0d, checks: %0d, errors: %0d", ops, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: tb/aqp_golden.txt
# W addr data | R addr d_out d_oe | P cassette_in printer_in | C cassette_out printer_out
# M addr wr ram_ce_n cart_ce_n ram_we_n ba d_oe (all fields hex, wr 1 = write)
R 00F0 C0 1
R 00F1 21 1
R 00F2 22 1
R 00F3 13 1
R 00FB 00 1
C 0 0
M 4000 0 0 1 1 01 0
M C000 0 1 0 1 13 0
W 00F1 2A
R 00F1 2A 1
M 4000 1 0 1 0 0A 0
W 00F2 11
R 00F2 11 1
M 8123 0 1 0 1 11 0
M 3800 1 0 1 0 00 0
M 3800 0 0 1 1 00 0
M 3000 0 1 1 1 00 1
W 00F0 02
M 0100 0 1 1 1 02 1
W 00F2 15
M 8000 0 1 1 1 15 1
W 00F0 C0
W 00F1 A1
M 4000 1 1 1 1 01 0
M 4000 0 0 1 1 01 0
W 00FB 03
R 00F1 00 0
R 00FB 03 1
W 00FB 00
R 00F1 A1 1
W 00FC 01
W 00FE 01
C 1 1
W 00FC 00
C 0 1
P 0 0
R 00FC 01 1
R 00FE 00 1
P 1 1
R 00FC 00 1
R 00FE 01 1

// File: compile.f
+incdir+hw
hw/aqp_pkg.sv
hw/host_bus_if.sv
hw/bus_sync.sv
hw/io_regs.sv
hw/mem_map.sv
hw/aqp_bus_top.sv
tb/tb_aqp_bus.sv

// File: Bender.yml
package:
  name: aqp_bus

sources:
  - include_dirs:
      - hw
    files:
      - hw/aqp_pkg.sv
      - hw/host_bus_if.sv
      - hw/bus_sync.sv
      - hw/io_regs.sv
      - hw/mem_map.sv
      - hw/aqp_bus_top.sv
  - target: test
    files:
      - tb/tb_aqp_bus.sv
